/* Bender.yml */
package:
  name: pcs_rx

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pcs_rx_pkg.sv
      - logic/am_elastic_fifo.sv
      - logic/clock_comp_rx.sv
      - logic/rx_block_decoder.sv
      - logic/rx_state_control.sv
      - logic/pcs_rx_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/pcs_rx_checker.sv
      - testbench/pcs_rx_tb.sv

/* logic/am_elastic_fifo.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module am_elastic_fifo
#(
    parameter int NB_DATA  = `PCS_NB_BLOCK,
    parameter int DEPTH    = `PCS_FIFO_DEPTH,   // Power of two, pointers wrap
    parameter int NB_ADDR  = $clog2(DEPTH),
    parameter int NB_COUNT = $clog2(DEPTH + 1)
)
(
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_flush,
    input  wire                  i_write,
    input  wire                  i_read,
    input  wire  [NB_DATA-1:0]   i_data,
    output logic [NB_DATA-1:0]   o_data,
    output logic [NB_COUNT-1:0]  o_count
);

localparam logic [NB_COUNT-1:0] COUNT_FULL = NB_COUNT'(DEPTH);

logic [NB_DATA-1:0]  mem [DEPTH];
logic [NB_ADDR-1:0]  wr_ptr;
logic [NB_ADDR-1:0]  rd_ptr;
logic [NB_COUNT-1:0] count;
logic                empty;
logic                full;

assign empty   = (count == '0);
assign full    = (count == COUNT_FULL);
assign o_count = count;

// Show-ahead head, input falls through when nothing is stored
// Covers a pop right after a marker burst drained the buffer
assign o_data = empty ? i_data : mem[rd_ptr];

always_ff @(posedge i_clock)
begin
    if (i_write)
        mem[wr_ptr] <= i_data;
end

always_ff @(posedge i_clock)
begin
    if (i_reset || i_flush)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end
    else
    begin
        if (i_write)
            wr_ptr <= wr_ptr + 1'b1;
        if (i_read)
            rd_ptr <= rd_ptr + 1'b1;
        case ({i_write, i_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Both or neither, level holds
        endcase
    end
end

// Caller must keep the level in range, no back-pressure exists
a_no_overflow: assert property (@(posedge i_clock) disable iff (i_reset || i_flush)
    i_write && full |-> i_read);
a_no_underflow: assert property (@(posedge i_clock) disable iff (i_reset || i_flush)
    i_read && empty |-> i_write);

endmodule

`default_nettype wire

/* logic/clock_comp_rx.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module clock_comp_rx
    import pcs_rx_pkg::*;
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_enable,
    input  wire                        i_valid,
    input  wire                        i_am_tag,
    input  wire  [`PCS_NB_BLOCK-1:0]   i_data,
    input  wire                        i_rx_in_control,
    output logic                       o_valid,
    output logic [`PCS_NB_BLOCK-1:0]   o_data
);

localparam int NB_DEFICIT = $clog2(2 * `PCS_N_LANES + 1);
localparam int NB_COUNT   = $clog2(`PCS_FIFO_DEPTH + 1);

localparam logic [NB_COUNT-1:0]   PRIME_LEVEL = NB_COUNT'(`PCS_FIFO_PRIME);
localparam logic [NB_DEFICIT-1:0] DEFICIT_MAX = NB_DEFICIT'(2 * `PCS_N_LANES);

pcs_block_u            head;         // FIFO head
logic [NB_COUNT-1:0]   fifo_count;
logic [NB_DEFICIT-1:0] deficit;      // Idles owed for dropped markers
logic                  primed;
logic                  ready;
logic                  run;
logic                  tag_seen;
logic                  head_is_idle;
logic                  insert_idle;
logic                  fifo_write;
logic                  fifo_read;

assign run      = i_valid && i_enable;
assign tag_seen = run && i_am_tag;
assign ready    = primed || (fifo_count >= PRIME_LEVEL);  // Primed this cycle or earlier

assign head_is_idle = (head.ctrl.sync == SYNC_CTRL) && (head.ctrl.block_type == BT_IDLE)
                      && (head.ctrl.payload == '0);

// Repeat the head idle between frames instead of popping it
assign insert_idle = run && ready && (deficit != '0) && head_is_idle && i_rx_in_control;

assign fifo_write = run && !i_am_tag;        // Markers never enter
assign fifo_read  = run && ready && !insert_idle;

always_ff @(posedge i_clock)
begin
    if (i_reset || !i_enable)
        primed <= 1'b0;
    else
        primed <= ready;                     // Sticky once level reached
end

always_ff @(posedge i_clock)
begin
    if (i_reset || !i_enable)
        deficit <= '0;
    else if (tag_seen && !insert_idle)
        deficit <= deficit + 1'b1;
    else if (insert_idle && !tag_seen)
        deficit <= deficit - 1'b1;
end

always_ff @(posedge i_clock)
begin
    if (i_reset || !i_enable)
        o_valid <= 1'b0;
    else
        o_valid <= run && ready;             // One block out per valid cycle
end

always_ff @(posedge i_clock)
begin
    o_data <= head;                          // Inserted idle is the unpopped head
end

am_elastic_fifo u_fifo
(
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_flush (!i_enable),
    .i_write (fifo_write),
    .i_read  (fifo_read),
    .i_data  (i_data),
    .o_data  (head),
    .o_count (fifo_count)
);

// Markers must be spaced so the receiver finds enough gaps to pay them back
a_deficit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
    deficit <= DEFICIT_MAX);

endmodule

`default_nettype wire

/* logic/pcs_rx_config.svh */
`ifndef PCS_RX_CONFIG_SVH
`define PCS_RX_CONFIG_SVH

// Coded block width, 2 sync bits plus 64 payload bits
`define PCS_NB_BLOCK 66

// Physical lanes, one marker per lane per marker period
`define PCS_N_LANES 4

// Elastic buffer size in blocks
`define PCS_FIFO_DEPTH 16

// Blocks held before the first read
`define PCS_FIFO_PRIME 4

`endif

/* logic/pcs_rx_pkg.sv */
`default_nettype none

`include "pcs_rx_config.svh"

package pcs_rx_pkg;

    // One coded block seen two ways
    typedef union packed {
        struct packed {
            logic [1:0]                  sync;
            logic [`PCS_NB_BLOCK-3:0]    payload;   // 8 data octets
        } data;
        struct packed {
            logic [1:0]                  sync;
            logic [7:0]                  block_type;
            logic [`PCS_NB_BLOCK-11:0]   payload;   // 7 control/data octets
        } ctrl;
    } pcs_block_u;

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    localparam logic [7:0] BT_IDLE  = 8'h1e;  // Also carries error codes
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM  = 8'h87;  // Terminate with no data octets

    typedef enum logic [2:0] {
        KIND_DATA,
        KIND_START,
        KIND_TERM,
        KIND_IDLE,
        KIND_CTRL_OTHER,
        KIND_BAD
    } block_kind_e;

    typedef enum logic [1:0] {
        RX_INIT,
        RX_C,
        RX_D,
        RX_E
    } rx_state_e;

endpackage

`default_nettype wire

/* logic/pcs_rx_top.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module pcs_rx_top
    import pcs_rx_pkg::*;
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_enable,
    input  wire                        i_valid,
    input  wire                        i_am_tag,
    input  wire  [`PCS_NB_BLOCK-1:0]   i_data,
    output logic                       o_valid,
    output logic [`PCS_NB_BLOCK-1:0]   o_data,
    output block_kind_e                o_block_kind,
    output rx_state_e                  o_rx_state,
    output logic                       o_rx_error
);

logic                      cc_valid;       // Compensated stream
logic [`PCS_NB_BLOCK-1:0]  cc_data;
logic                      rx_in_control;  // Loop back from the FSM

clock_comp_rx u_clock_comp
(
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_enable        (i_enable),
    .i_valid         (i_valid),
    .i_am_tag        (i_am_tag),
    .i_data          (i_data),
    .i_rx_in_control (rx_in_control),
    .o_valid         (cc_valid),
    .o_data          (cc_data)
);

rx_block_decoder u_decoder
(
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_valid      (cc_valid),
    .i_data       (cc_data),
    .o_valid      (o_valid),
    .o_data       (o_data),
    .o_block_kind (o_block_kind)
);

rx_state_control u_state_control
(
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_enable        (i_enable),
    .i_valid         (o_valid),
    .i_block_kind    (o_block_kind),
    .o_rx_state      (o_rx_state),
    .o_rx_error      (o_rx_error),
    .o_rx_in_control (rx_in_control)
);

endmodule

`default_nettype wire

/* logic/rx_block_decoder.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module rx_block_decoder
    import pcs_rx_pkg::*;
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_valid,
    input  wire  [`PCS_NB_BLOCK-1:0]   i_data,
    output logic                       o_valid,
    output logic [`PCS_NB_BLOCK-1:0]   o_data,
    output block_kind_e                o_block_kind
);

pcs_block_u  blk;
block_kind_e kind;

assign blk = i_data;

// Sync header picks the view, block type picks the kind
always_comb
begin
    case (blk.data.sync)
        SYNC_DATA:
            kind = KIND_DATA;
        SYNC_CTRL:
        begin
            case (blk.ctrl.block_type)
                BT_IDLE:
                begin
                    if (blk.ctrl.payload == '0)
                        kind = KIND_IDLE;
                    else
                        kind = KIND_CTRL_OTHER;  // Error or other control codes
                end
                BT_START: kind = KIND_START;
                BT_TERM:  kind = KIND_TERM;
                default:  kind = KIND_BAD;       // Unknown block type
            endcase
        end
        default:
            kind = KIND_BAD;                     // Header 00 or 11
    endcase
end

always_ff @(posedge i_clock)
begin
    if (i_reset)
        o_valid <= 1'b0;
    else
        o_valid <= i_valid;
end

always_ff @(posedge i_clock)
begin
    if (i_valid)
    begin
        o_data       <= i_data;
        o_block_kind <= kind;   // Stays aligned with the block
    end
end

endmodule

`default_nettype wire

/* logic/rx_state_control.sv */
`default_nettype none

module rx_state_control
    import pcs_rx_pkg::*;
(
    input  wire          i_clock,
    input  wire          i_reset,
    input  wire          i_enable,
    input  wire          i_valid,
    input  block_kind_e  i_block_kind,
    output rx_state_e    o_rx_state,
    output logic         o_rx_error,
    output logic         o_rx_in_control
);

rx_state_e state;
rx_state_e state_next;

always_comb
begin
    state_next = state;
    case (state)
        RX_INIT, RX_C:
        begin
            case (i_block_kind)
                KIND_IDLE, KIND_CTRL_OTHER: state_next = RX_C;
                KIND_START:                 state_next = RX_D;
                default:                    state_next = RX_E;  // Data or term outside frame
            endcase
        end
        RX_D:
        begin
            case (i_block_kind)
                KIND_DATA: state_next = RX_D;
                KIND_TERM: state_next = RX_C;
                default:   state_next = RX_E;   // Frame cut short
            endcase
        end
        default:
        begin
            if (i_block_kind == KIND_IDLE)
                state_next = RX_C;              // Recover on next idle
        end
    endcase
end

always_ff @(posedge i_clock)
begin
    if (i_reset || !i_enable)
    begin
        state      <= RX_INIT;
        o_rx_error <= 1'b0;
    end
    else
    begin
        // Pulse only on entry
        o_rx_error <= i_valid && (state_next == RX_E) && (state != RX_E);
        if (i_valid)
            state <= state_next;
    end
end

assign o_rx_state      = state;
assign o_rx_in_control = (state == RX_C);  // Grants idle insertion upstream

// Control is entered only from a valid control-class block
a_control_entry: assert property (@(posedge i_clock) disable iff (i_reset || !i_enable)
    $rose(o_rx_in_control) |-> $past(i_valid)
    && ($past(i_block_kind) inside {KIND_IDLE, KIND_CTRL_OTHER, KIND_TERM}));

endmodule

`default_nettype wire

/* pcs_rx_top.f */
+incdir+logic
logic/pcs_rx_pkg.sv
logic/am_elastic_fifo.sv
logic/clock_comp_rx.sv
logic/rx_block_decoder.sv
logic/rx_state_control.sv
logic/pcs_rx_top.sv
testbench/pcs_rx_checker.sv
testbench/pcs_rx_tb.sv

/* testbench/pcs_rx_checker.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module pcs_rx_checker
    import pcs_rx_pkg::*;
(
    input  wire                        i_clock,
    input  wire                        i_valid,
    input  wire  [`PCS_NB_BLOCK-1:0]   i_data,
    input  block_kind_e                i_block_kind,
    input  rx_state_e                  i_rx_state,
    input  wire                        i_rx_error,
    output int                         o_out_count,
    output int                         o_fail_count
);

// Plain idle as built by the receiver
localparam logic [`PCS_NB_BLOCK-1:0] IDLE_BLOCK =
    {SYNC_CTRL, BT_IDLE, {(`PCS_NB_BLOCK-10){1'b0}}};

logic [`PCS_NB_BLOCK-1:0] exp_data [$];   // Non-idle blocks still owed
block_kind_e              exp_kind [$];
logic [`PCS_NB_BLOCK-1:0] want_data;
block_kind_e              want_kind;
string                    test_name;
bit                       checking;
bit                       in_frame;       // Between start and terminate
int                       idle_count;
int                       error_count;
int                       test_errors;

initial
begin
    o_out_count  = 0;
    o_fail_count = 0;
    checking     = 1'b0;
end

task automatic compare_value(input string name, input logic [`PCS_NB_BLOCK-1:0] got,
                             input logic [`PCS_NB_BLOCK-1:0] want);
    if (got !== want)
    begin
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
        test_errors++;
        o_fail_count++;
    end
endtask

task automatic report_problem(input string what);
    $display("Error at %0t in %s: %s", $time, test_name, what);
    test_errors++;
    o_fail_count++;
endtask

task automatic start_test(input string name, input bit check);
    test_name   = name;
    checking    = check;          // Off while a stream is only warming up
    exp_data.delete();
    exp_kind.delete();
    o_out_count = 0;
    idle_count  = 0;
    error_count = 0;
    test_errors = 0;
    in_frame    = 1'b0;
endtask

task automatic expect_block(input logic [`PCS_NB_BLOCK-1:0] blk, input block_kind_e kind);
    exp_data.push_back(blk);
    exp_kind.push_back(kind);
endtask

always @(posedge i_clock)
begin
    if (checking && i_valid)
    begin
        o_out_count <= o_out_count + 1;       // Read by the waiting loop
        if (i_data === IDLE_BLOCK)
        begin
            idle_count++;
            compare_value("o_block_kind", i_block_kind, KIND_IDLE);
            if (in_frame)
                report_problem("idle block inserted inside a frame");
        end
        else if (exp_data.size() == 0)
            report_problem("non-idle block appeared that the input never carried");
        else
        begin
            want_data = exp_data.pop_front();
            want_kind = exp_kind.pop_front();
            compare_value("o_data", i_data, want_data);
            compare_value("o_block_kind", i_block_kind, want_kind);
            if (want_kind == KIND_START)
                in_frame = 1'b1;
            else if (want_kind == KIND_TERM)
                in_frame = 1'b0;
        end
    end
    if (checking && i_rx_error)
    begin
        error_count++;
        compare_value("o_rx_state", i_rx_state, RX_E);  // Same edge as the pulse
    end
end

task automatic finish_test(input int want_count, input int want_idles, input int want_errors,
                           output bit ok);
    compare_value("o_valid count", o_out_count, want_count);
    compare_value("idle count", idle_count, want_idles);
    compare_value("o_rx_error count", error_count, want_errors);
    compare_value("o_rx_state", i_rx_state, RX_C);   // Settled in the tail
    if (exp_data.size() != 0)
        report_problem($sformatf("%0d expected blocks never came out", exp_data.size()));
    ok = (test_errors == 0);
    $display("Test %-18s %s  outputs %0d  idles %0d  errors %0d", test_name,
             ok ? "ok" : "FAILED", o_out_count, idle_count, error_count);
    checking = 1'b0;
endtask

endmodule

`default_nettype wire

/* testbench/pcs_rx_tb.sv */
`default_nettype none

`include "pcs_rx_config.svh"

module pcs_rx_tb
    import pcs_rx_pkg::*;
();

localparam int WAIT_LIMIT = 64;               // Cycles allowed for the pipeline tail
localparam int PRIME      = `PCS_FIFO_PRIME;

logic                      clock;
logic                      reset;
logic                      enable;
logic                      valid;
logic                      am_tag;
logic [`PCS_NB_BLOCK-1:0]  data;
logic                      out_valid;
logic [`PCS_NB_BLOCK-1:0]  out_data;
block_kind_e               out_kind;
rx_state_e                 out_state;
logic                      out_error;
int                        out_count;
int                        fail_count;

integer                    seed;
int                        tests_run;
int                        tests_failed;
int                        timeouts;
logic [`PCS_NB_BLOCK-1:0]  stim_data [$];   // One entry per valid cycle
logic                      stim_tag  [$];
block_kind_e               stim_kind [$];

pcs_rx_top DUT
(
    .i_clock      (clock),
    .i_reset      (reset),
    .i_enable     (enable),
    .i_valid      (valid),
    .i_am_tag     (am_tag),
    .i_data       (data),
    .o_valid      (out_valid),
    .o_data       (out_data),
    .o_block_kind (out_kind),
    .o_rx_state   (out_state),
    .o_rx_error   (out_error)
);

pcs_rx_checker u_checker
(
    .i_clock      (clock),
    .i_valid      (out_valid),
    .i_data       (out_data),
    .i_block_kind (out_kind),
    .i_rx_state   (out_state),
    .i_rx_error   (out_error),
    .o_out_count  (out_count),
    .o_fail_count (fail_count)
);

initial
begin
    clock = 1'b0;
    forever #4 clock = ~clock;
end

function automatic logic [63:0] random64();
    return {$random(seed), $random(seed)};
endfunction

function automatic logic [`PCS_NB_BLOCK-1:0] ctrl_block(input logic [7:0] block_type);
    logic [63:0] r;
    r = random64();
    return {SYNC_CTRL, block_type, r[`PCS_NB_BLOCK-11:0]};   // Random octets behind the type
endfunction

// Non-idle order with markers gone, and the idle total at the output
function automatic int expected_stream(
    input  logic [`PCS_NB_BLOCK-1:0] blocks [$],
    input  logic                     tags   [$],
    input  block_kind_e              kinds  [$],
    output logic [`PCS_NB_BLOCK-1:0] want_data [$],
    output block_kind_e              want_kind [$]);
    int idles;
    idles = 0;
    foreach (blocks[i])
    begin
        if (tags[i] || kinds[i] == KIND_IDLE)
            idles++;                           // Every dropped marker comes back as an idle
        else
        begin
            want_data.push_back(blocks[i]);
            want_kind.push_back(kinds[i]);
        end
    end
    return idles - PRIME;                      // Last tail idles stay buffered
endfunction

task automatic add_block(input logic [`PCS_NB_BLOCK-1:0] blk, input logic tag,
                         input block_kind_e kind);
    stim_data.push_back(blk);
    stim_tag.push_back(tag);
    stim_kind.push_back(kind);
endtask

task automatic add_idles(input int n);
    repeat (n) add_block({SYNC_CTRL, BT_IDLE, {(`PCS_NB_BLOCK-10){1'b0}}}, 1'b0, KIND_IDLE);
endtask

task automatic add_markers();
    repeat (`PCS_N_LANES) add_block({SYNC_CTRL, random64()}, 1'b1, KIND_CTRL_OTHER);
endtask

task automatic add_frame(input int n_data, input bit mid_markers);
    int i;
    add_block(ctrl_block(BT_START), 1'b0, KIND_START);
    for (i = 0; i < n_data; i++)
    begin
        add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
        if (mid_markers && i == n_data / 2)
            add_markers();                      // Burst lands inside the frame
    end
    add_block(ctrl_block(BT_TERM), 1'b0, KIND_TERM);
endtask

task automatic build_frames(input int n_frames, input bit between, input bit mid);
    int f;
    add_idles(8);                                // Priming happens on idles
    for (f = 0; f < n_frames; f++)
    begin
        add_frame(2 + ($unsigned($random(seed)) % 6), mid);
        add_idles(10);                           // Earlier deficit paid off first
        if (between)
            add_markers();
        add_idles(8 + ($unsigned($random(seed)) % 8));
    end
    add_idles(24);                               // Long tail drains the deficit
endtask

task automatic clear_stim();
    stim_data.delete();
    stim_tag.delete();
    stim_kind.delete();
endtask

task automatic drive_stream();
    int i;
    for (i = 0; i < stim_data.size(); i++)
    begin
        @(posedge clock);
        valid  <= 1'b1;
        am_tag <= stim_tag[i];
        data   <= stim_data[i];
    end
    @(posedge clock);
    valid  <= 1'b0;
    am_tag <= 1'b0;
endtask

task automatic wait_outputs(input int want);
    int cycles;
    cycles = 0;
    while (out_count < want && cycles < WAIT_LIMIT)
    begin
        @(posedge clock);
        cycles++;
    end
    if (out_count < want)
    begin
        $display("Timeout after %0d cycles: expected %0d output blocks but saw %0d",
                 cycles, want, out_count);
        timeouts++;
    end
endtask

task automatic run_test(input string name, input int want_errors);
    logic [`PCS_NB_BLOCK-1:0] want_data [$];
    block_kind_e              want_kind [$];
    int                       want_idles;
    bit                       ok;
    want_idles = expected_stream(stim_data, stim_tag, stim_kind, want_data, want_kind);
    u_checker.start_test(name, 1'b1);
    foreach (want_data[i])
        u_checker.expect_block(want_data[i], want_kind[i]);
    drive_stream();
    wait_outputs(stim_data.size() - PRIME);
    repeat (4) @(posedge clock);                 // Let the FSM see the last block
    u_checker.finish_test(stim_data.size() - PRIME, want_idles, want_errors, ok);
    tests_run++;
    if (!ok)
        tests_failed++;
    clear_stim();
    enable <= 1'b0;                              // Flush so the next test starts clean
    repeat (2) @(posedge clock);
    enable <= 1'b1;
endtask

initial
begin
    seed         = 32'h1c62ed17;
    tests_run    = 0;
    tests_failed = 0;
    timeouts     = 0;
    reset        = 1'b1;
    enable       = 1'b1;
    valid        = 1'b0;
    am_tag       = 1'b0;
    data         = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);

    build_frames(6, 1'b0, 1'b0);
    run_test("pass-through", 0);
    build_frames(6, 1'b1, 1'b0);
    run_test("marker removal", 0);
    build_frames(8, 1'b1, 1'b1);
    run_test("idle compensation", 0);
    build_frames(6, 1'b0, 1'b1);
    run_test("frame integrity", 0);

    // Bad sync header, then data with no start
    add_idles(8);
    add_block({2'b11, random64()}, 1'b0, KIND_BAD);
    add_idles(4);
    add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
    add_idles(24);
    run_test("error detection", 2);

    // Frame cut by enable while marker idles are still owed
    add_idles(8);
    add_block(ctrl_block(BT_START), 1'b0, KIND_START);
    add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
    add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
    add_markers();
    add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
    add_block({SYNC_DATA, random64()}, 1'b0, KIND_DATA);
    u_checker.start_test("enable warmup", 1'b0);
    drive_stream();
    clear_stim();
    enable <= 1'b0;
    repeat (4) @(posedge clock);
    enable <= 1'b1;
    build_frames(4, 1'b0, 1'b0);
    run_test("enable clear", 0);

    $display("Tests run %0d, failed %0d, check errors %0d, timeouts %0d",
             tests_run, tests_failed, fail_count, timeouts);
    if (tests_failed == 0 && fail_count == 0 && timeouts == 0)
        $display("Simulation finished: PASS");
    else
        $display("Simulation finished: FAIL");
    $finish;
end

endmodule

`default_nettype wire
